// File: verilog/qbuf_pkg.sv
// Packet buffer shared definitions
// Sizes, vector types and the structs passed between the buffer blocks
package qbuf_pkg;

    // Sizes
    localparam int data_bytes      = 4;
    localparam int words_per_page  = 4;
    localparam int num_pages       = 16;
    localparam int num_queues      = 4;
    localparam int queues_per_port = 2;
    localparam int mem_depth       = num_pages * words_per_page;

    // Queue q starts on pages 2q and 2q+1, the rest are free
    localparam int first_free_page = 2 * num_queues;
    localparam int init_free_pages = num_pages - first_free_page;
    localparam int word_count_w    = $clog2(mem_depth) + 1;

    typedef logic [8*data_bytes-1:0]                       word_t;
    typedef logic [data_bytes-1:0]                         keep_t;
    typedef logic [$clog2(data_bytes)-1:0]                 keep_code_t;
    typedef logic [$clog2(num_pages)-1:0]                  page_t;
    typedef logic [$clog2(words_per_page)-1:0]             offset_t;
    typedef logic [$clog2(num_queues)-1:0]                 queue_id_t;
    typedef logic [$clog2(num_queues/queues_per_port)-1:0] port_t;
    typedef logic [$clog2(data_bytes):0]                   byte_count_t;
    typedef logic [$clog2(num_pages):0]                    page_count_t;

    // AXI4-Lite response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef struct packed {
        logic      valid;
        word_t     data;
        keep_t     keep;
        logic      last;
        queue_id_t qid;
    } enq_word_t;

    typedef struct packed {
        page_t   page;
        offset_t offset;
    } mem_addr_t;

    typedef struct packed {
        logic      arvalid;
        queue_id_t araddr;
    } axil_ar_t;

    typedef struct packed {
        logic       rvalid;
        logic [1:0] rresp;
        mem_addr_t  rdata;
    } axil_r_t;

    typedef struct packed {
        logic      valid;
        queue_id_t qid;
    } deq_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
        keep_t keep;
        logic  last;
        port_t port;
    } word_out_t;

    typedef struct packed {
        logic        valid;
        queue_id_t   qid;
        byte_count_t bytes;
        logic        last;
    } deq_notice_t;

    typedef struct packed {
        logic  valid;
        page_t page;
    } page_release_t;

endpackage

// File: verilog/page_free_list.sv
// Free page list
// Circular FIFO of unused page numbers, popped on allocation and pushed on release
`timescale 1ns/1ps

module page_free_list
    import qbuf_pkg::*;
(
    input  logic          packet_in,
    input  logic          rst_n,
    input  logic          pop,
    output page_t         pop_page,
    input  page_release_t release_req,
    output page_count_t   free_pages
);

    typedef logic [$clog2(num_pages)-1:0] slot_t;

    page_t fifo [num_pages];
    slot_t rd_ptr;
    slot_t wr_ptr;

    // Head entry is always visible so the allocator takes it without a wait
    assign pop_page = fifo[rd_ptr];

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            rd_ptr     <= '0;
            wr_ptr     <= slot_t'(init_free_pages);
            free_pages <= page_count_t'(init_free_pages);
            for (int i = 0; i < init_free_pages; i++) begin
                fifo[i] <= page_t'(first_free_page + i);
            end
        end else begin
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (release_req.valid) begin
                fifo[wr_ptr] <= release_req.page;
                wr_ptr       <= wr_ptr + 1'b1;
            end
            // Simultaneous push and pop cancel out
            free_pages <= free_pages + page_count_t'(release_req.valid) - page_count_t'(pop);
        end
    end

endmodule

// File: verilog/queue_pointer_table.sv
// Queue pointer table
// Per-queue head/tail/spare pages, page links, write addresses and head-pointer reads
`timescale 1ns/1ps

module queue_pointer_table
    import qbuf_pkg::*;
(
    input  logic      packet_in,
    input  logic      rst_n,
    input  enq_word_t enq,
    output mem_addr_t wr_addr,
    input  axil_ar_t  ar,
    output axil_r_t   r,
    output logic      alloc,
    input  page_t     alloc_page
);

    typedef enum logic {
        idle,
        respond
    } rd_state_t;

    typedef logic [word_count_w-1:0] word_count_t;

    mem_addr_t   tail  [num_queues];
    mem_addr_t   head  [num_queues];
    page_t       spare [num_queues];
    word_count_t count [num_queues];
    page_t       link  [num_pages];

    logic                  page_turn;
    logic                  enq_d_valid;
    queue_id_t             enq_d_qid;
    logic                  rd_hit;
    mem_addr_t             head_sel;
    logic [num_queues-1:0] cnt_inc;
    logic [num_queues-1:0] cnt_dec;
    rd_state_t             state;
    logic [1:0]            resp_q;
    mem_addr_t             addr_q;

    ////////////////////////////////////////////////////////////////////////////
    // Tail side

    assign wr_addr   = tail[enq.qid];
    assign page_turn = enq.valid && (wr_addr.offset == offset_t'(words_per_page - 1));
    assign alloc     = page_turn;

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            for (int q = 0; q < num_queues; q++) begin
                tail[q]  <= '{page: page_t'(2 * q), offset: '0};
                spare[q] <= page_t'(2 * q + 1);
            end
        end else if (enq.valid) begin
            if (page_turn) begin
                // Continue on the spare, refill it from the free list
                tail[enq.qid]  <= '{page: spare[enq.qid], offset: '0};
                spare[enq.qid] <= alloc_page;
            end else begin
                tail[enq.qid] <= '{page: wr_addr.page, offset: wr_addr.offset + 1'b1};
            end
        end
    end

    always_ff @(posedge packet_in) begin
        if (page_turn) begin
            link[wr_addr.page] <= spare[enq.qid];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Word counts

    // Count rises one cycle after the table sees the word, when memory commits it
    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            enq_d_valid <= 1'b0;
        end else begin
            enq_d_valid <= enq.valid;
            enq_d_qid   <= enq.qid;
        end
    end

    always_comb begin
        for (int q = 0; q < num_queues; q++) begin
            cnt_inc[q] = enq_d_valid && (enq_d_qid == queue_id_t'(q));
            cnt_dec[q] = rd_hit && (ar.araddr == queue_id_t'(q));
        end
    end

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            for (int q = 0; q < num_queues; q++) begin
                count[q] <= '0;
            end
        end else begin
            for (int q = 0; q < num_queues; q++) begin
                count[q] <= count[q] + word_count_t'(cnt_inc[q]) - word_count_t'(cnt_dec[q]);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Head side and AXI4-Lite read channel

    assign head_sel = head[ar.araddr];
    assign rd_hit   = ar.arvalid && (count[ar.araddr] != '0);

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            state <= idle;
            for (int q = 0; q < num_queues; q++) begin
                head[q] <= '{page: page_t'(2 * q), offset: '0};
            end
        end else begin
            state <= ar.arvalid ? respond : idle;
            if (rd_hit) begin
                if (head_sel.offset == offset_t'(words_per_page - 1)) begin
                    head[ar.araddr] <= '{page: link[head_sel.page], offset: '0};
                end else begin
                    head[ar.araddr] <= '{page: head_sel.page, offset: head_sel.offset + 1'b1};
                end
            end
        end
    end

    // Empty queue answers SLVERR and leaves everything alone
    always_ff @(posedge packet_in) begin
        if (ar.arvalid) begin
            resp_q <= rd_hit ? resp_okay : resp_slverr;
            addr_q <= head_sel;
        end
    end

    assign r.rvalid = (state == respond);
    assign r.rresp  = resp_q;
    assign r.rdata  = addr_q;

endmodule

// File: verilog/queue_word_memory.sv
// Queue word memory
// Paged data and byte-length storage with enqueue write and dequeue read pipelines
`timescale 1ns/1ps

module queue_word_memory
    import qbuf_pkg::*;
(
    input  logic          packet_in,
    input  logic          rst_n,
    input  enq_word_t     enq,
    input  mem_addr_t     wr_addr,
    input  deq_req_t      deq_req,
    output axil_ar_t      ar,
    input  axil_r_t       r,
    output word_out_t     word_out,
    output deq_notice_t   deq_notice,
    output page_release_t page_release
);

    typedef struct packed {
        keep_code_t code;
        logic       last;
    } len_entry_t;

    word_t      data_mem [mem_depth];
    len_entry_t len_mem  [mem_depth];

    logic       wr_en;
    mem_addr_t  wr_addr_q;
    word_t      wr_data_q;
    len_entry_t wr_len_q;

    queue_id_t  qid_dly [2];
    logic       rd_ok;
    logic       rd_valid_q;
    word_t      rd_data_q;
    len_entry_t rd_len_q;

    ////////////////////////////////////////////////////////////////////////////
    // Byte mask coding

    // Full mask maps to zero, otherwise the number of low valid bytes
    function automatic keep_code_t encode_keep(keep_t keep);
        keep_code_t code;
        code = '0;
        for (int i = data_bytes - 1; i >= 1; i--) begin
            if (!keep[i]) begin
                code = keep_code_t'(i);
            end
        end
        return code;
    endfunction

    function automatic keep_t decode_keep(keep_code_t code);
        keep_t keep;
        keep = '1;
        if (code != '0) begin
            for (int i = 0; i < data_bytes; i++) begin
                keep[i] = (i < int'(code));
            end
        end
        return keep;
    endfunction

    function automatic byte_count_t code_to_bytes(keep_code_t code);
        return (code == '0) ? byte_count_t'(data_bytes) : byte_count_t'(code);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Enqueue, two stages

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= enq.valid;
        end
    end

    always_ff @(posedge packet_in) begin
        wr_addr_q <= wr_addr;
        wr_data_q <= enq.data;
        wr_len_q  <= '{code: encode_keep(enq.keep), last: enq.last};
        if (wr_en) begin
            data_mem[wr_addr_q] <= wr_data_q;
            len_mem[wr_addr_q]  <= wr_len_q;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Dequeue

    assign rd_ok = r.rvalid && (r.rresp == resp_okay);

    always_ff @(posedge packet_in) begin
        if (!rst_n) begin
            ar.arvalid         <= 1'b0;
            rd_valid_q         <= 1'b0;
            page_release.valid <= 1'b0;
            word_out.valid     <= 1'b0;
            deq_notice.valid   <= 1'b0;
        end else begin
            // Head pointer fetch
            ar.arvalid <= deq_req.valid;
            ar.araddr  <= deq_req.qid;
            qid_dly[0] <= ar.araddr;
            qid_dly[1] <= qid_dly[0];

            // Page is done once its last word has been read
            rd_valid_q         <= rd_ok;
            page_release.valid <= rd_ok && (r.rdata.offset == offset_t'(words_per_page - 1));
            page_release.page  <= r.rdata.page;

            word_out.valid   <= rd_valid_q;
            word_out.data    <= rd_data_q;
            word_out.keep    <= decode_keep(rd_len_q.code);
            word_out.last    <= rd_len_q.last;
            word_out.port    <= port_t'(qid_dly[1] / queues_per_port);

            deq_notice.valid <= rd_valid_q;
            deq_notice.qid   <= qid_dly[1];
            deq_notice.bytes <= code_to_bytes(rd_len_q.code);
            deq_notice.last  <= rd_len_q.last;
        end
    end

    // First read register straight off the memories
    always_ff @(posedge packet_in) begin
        rd_data_q <= data_mem[r.rdata];
        rd_len_q  <= len_mem[r.rdata];
    end

endmodule

// File: verilog/qbuf_top.sv
// Packet buffer top level
// Free list, pointer table and word memory of the egress queue stage
`timescale 1ns/1ps

module qbuf_top
    import qbuf_pkg::*;
(
    input  logic        packet_in,
    input  logic        rst_n,
    input  enq_word_t   enq,
    input  deq_req_t    deq_req,
    output word_out_t   word_out,
    output deq_notice_t deq_notice,
    output page_count_t free_pages
);

    mem_addr_t     wr_addr;
    axil_ar_t      ar;
    axil_r_t       r;
    logic          alloc;
    page_t         alloc_page;
    page_release_t page_release;

    page_free_list u_free_list (
        .packet_in   (packet_in),
        .rst_n       (rst_n),
        .pop         (alloc),
        .pop_page    (alloc_page),
        .release_req (page_release),
        .free_pages  (free_pages)
    );

    queue_pointer_table u_pointer_table (
        .packet_in  (packet_in),
        .rst_n      (rst_n),
        .enq        (enq),
        .wr_addr    (wr_addr),
        .ar         (ar),
        .r          (r),
        .alloc      (alloc),
        .alloc_page (alloc_page)
    );

    queue_word_memory u_word_memory (
        .packet_in    (packet_in),
        .rst_n        (rst_n),
        .enq          (enq),
        .wr_addr      (wr_addr),
        .deq_req      (deq_req),
        .ar           (ar),
        .r            (r),
        .word_out     (word_out),
        .deq_notice   (deq_notice),
        .page_release (page_release)
    );

endmodule

// File: tb/qbuf_properties.sv
// Packet buffer assertions
// Free list occupancy and pointer table read channel checks for both bound blocks
`timescale 1ns/1ps

module qbuf_properties
    import qbuf_pkg::*;
(
    input logic        packet_in,
    input logic        rst_n,
    input logic        pop,
    input page_count_t free_pages,
    input logic        arvalid,
    input logic        rvalid,
    input queue_id_t   araddr,
    input mem_addr_t   head_sel,
    input logic        head_empty
);

    no_pop_when_empty: assert property (
        @(posedge packet_in) disable iff (!rst_n) pop |-> (free_pages != '0)
    ) else $error("free list popped with no free page");

    free_count_in_range: assert property (
        @(posedge packet_in) disable iff (!rst_n) free_pages <= page_count_t'(num_pages)
    ) else $error("free page count above the number of pages");

    // R beat exactly one cycle behind its AR beat
    rvalid_after_arvalid: assert property (
        @(posedge packet_in) disable iff (!rst_n) arvalid |=> rvalid
    ) else $error("AR beat without an R beat on the next cycle");

    rvalid_needs_arvalid: assert property (
        @(posedge packet_in) disable iff (!rst_n) rvalid |-> $past(arvalid)
    ) else $error("R beat without an AR beat on the cycle before");

    // A read of an empty queue leaves that queue's head where it was
    no_advance_when_empty: assert property (
        @(posedge packet_in) disable iff (!rst_n)
            $past(arvalid && head_empty) && (araddr == $past(araddr))
            |-> (head_sel == $past(head_sel))
    ) else $error("head advanced on a queue holding no word");

endmodule

////////////////////////////////////////////////////////////////////////////
// Free list instance with the read channel inputs held idle

bind page_free_list qbuf_properties u_free_list_props (
    .packet_in  (packet_in),
    .rst_n      (rst_n),
    .pop        (pop),
    .free_pages (free_pages),
    .arvalid    (1'b0),
    .rvalid     (1'b0),
    .araddr     ('0),
    .head_sel   ('0),
    .head_empty (1'b0)
);

// Pointer table instance with the free list inputs held idle
bind queue_pointer_table qbuf_properties u_table_props (
    .packet_in  (packet_in),
    .rst_n      (rst_n),
    .pop        (1'b0),
    .free_pages ('0),
    .arvalid    (ar.arvalid),
    .rvalid     (r.rvalid),
    .araddr     (ar.araddr),
    .head_sel   (head[ar.araddr]),
    .head_empty (count[ar.araddr] == '0)
);

// File: tb/qbuf_tb.sv
// Packet buffer testbench
// Random enqueue and dequeue traffic checked against a per-queue word model
`timescale 1ns/1ps

module qbuf_tb
    import qbuf_pkg::*;
();

    localparam int reset_cycles  = 2;
    localparam int random_slots  = 500;
    localparam int drain_slots   = 150;
    localparam int settle_slots  = 8;
    localparam int total_slots   = random_slots + drain_slots + settle_slots;
    localparam int timeout_limit = total_slots + 50;
    localparam int ready_delay   = 3;
    localparam int out_latency   = 4;
    // Page use stays below 16 even with releases still in flight
    localparam int max_stored    = 12;

    typedef struct packed {
        word_t data;
        keep_t keep;
        logic  last;
        int    slot;
    } model_entry_t;

    typedef struct packed {
        logic      valid;
        word_t     data;
        keep_t     keep;
        logic      last;
        queue_id_t qid;
    } expected_t;

    logic        packet_in;
    logic        rst_n;
    enq_word_t   enq;
    deq_req_t    deq_req;
    word_out_t   word_out;
    deq_notice_t deq_notice;
    page_count_t free_pages;

    model_entry_t model_q [num_queues][$];
    expected_t    exp_out [total_slots];
    int           enq_count [num_queues];
    int           deq_count [num_queues];
    int           stored;
    int           pkt_left;
    queue_id_t    pkt_qid;
    int           error_count;
    int           cycle_count = 0;

    qbuf_top u_dut (
        .packet_in  (packet_in),
        .rst_n      (rst_n),
        .enq        (enq),
        .deq_req    (deq_req),
        .word_out   (word_out),
        .deq_notice (deq_notice),
        .free_pages (free_pages)
    );

    initial begin
        packet_in = 1'b0;
        forever begin
            #20 packet_in = ~packet_in;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Run length guard
    always @(posedge packet_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("ERROR: run went past %0d cycles without finishing", timeout_limit);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and model

    task automatic drive_enqueue(input int slot);
        enq_word_t    word;
        model_entry_t entry;
        int           len;
        word = '0;
        if (slot < random_slots && pkt_left == 0 && ($urandom % 4) != 0) begin
            len = 1 + int'($urandom % 6);
            if (stored + len <= max_stored) begin
                pkt_left = len;
                pkt_qid  = queue_id_t'($urandom % num_queues);
            end
        end
        // Packets in progress finish back to back once draining starts
        if (pkt_left != 0 && (slot >= random_slots || ($urandom % 4) != 0)) begin
            word.valid = 1'b1;
            word.data  = $urandom;
            word.qid   = pkt_qid;
            word.last  = (pkt_left == 1);
            word.keep  = word.last ? keep_t'((1 << (1 + ($urandom % data_bytes))) - 1) : '1;
            entry = '{data: word.data, keep: word.keep, last: word.last, slot: slot};
            model_q[pkt_qid].push_back(entry);
            enq_count[pkt_qid]++;
            stored++;
            pkt_left--;
        end
        enq <= word;
    endtask

    task automatic drive_dequeue(input int slot);
        deq_req_t     req;
        expected_t    exp;
        model_entry_t entry;
        queue_id_t    qid;
        req = '0;
        exp = '0;
        qid = queue_id_t'($urandom % num_queues);
        if (slot < random_slots + drain_slots &&
            (slot >= random_slots || ($urandom % 2) == 0)) begin
            if (model_q[qid].size() == 0) begin
                // Empty queue gives no output
                req = '{valid: 1'b1, qid: qid};
            end else if (model_q[qid][0].slot + ready_delay <= slot) begin
                entry = model_q[qid].pop_front();
                req   = '{valid: 1'b1, qid: qid};
                exp   = '{valid: 1'b1, data: entry.data, keep: entry.keep,
                          last: entry.last, qid: qid};
                deq_count[qid]++;
                stored--;
            end
        end
        exp_out[slot] = exp;
        deq_req <= req;
    endtask

    task automatic check_outputs(input int slot);
        expected_t exp;
        exp = '0;
        if (slot >= out_latency) begin
            exp = exp_out[slot - out_latency];
        end
        check_value("word_out.valid", 64'(exp.valid), 64'(word_out.valid));
        check_value("deq_notice.valid", 64'(exp.valid), 64'(deq_notice.valid));
        if (exp.valid) begin
            check_value("word_out.data", 64'(exp.data), 64'(word_out.data));
            check_value("word_out.keep", 64'(exp.keep), 64'(word_out.keep));
            check_value("word_out.last", 64'(exp.last), 64'(word_out.last));
            // Port is the upper bit of the queue number
            check_value("word_out.port", 64'(exp.qid[$bits(queue_id_t)-1]),
                        64'(word_out.port));
            check_value("deq_notice.qid", 64'(exp.qid), 64'(deq_notice.qid));
            check_value("deq_notice.bytes", 64'($countones(exp.keep)),
                        64'(deq_notice.bytes));
            check_value("deq_notice.last", 64'(exp.last), 64'(deq_notice.last));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int expected_free;
        void'($urandom(26));
        rst_n   <= 1'b0;
        enq     <= '0;
        deq_req <= '0;
        stored      = 0;
        pkt_left    = 0;
        pkt_qid     = '0;
        error_count = 0;
        for (int q = 0; q < num_queues; q++) begin
            enq_count[q] = 0;
            deq_count[q] = 0;
        end
        repeat (reset_cycles) @(posedge packet_in);
        rst_n <= 1'b1;

        for (int slot = 0; slot < total_slots; slot++) begin
            @(posedge packet_in);
            drive_enqueue(slot);
            drive_dequeue(slot);
            @(negedge packet_in);
            check_outputs(slot);
        end

        // Drained traffic leaves only whole pages to account for
        expected_free = num_pages - 2 * num_queues;
        for (int q = 0; q < num_queues; q++) begin
            if (model_q[q].size() != 0) begin
                $display("ERROR: queue %0d still holds %0d words after the drain phase",
                         q, model_q[q].size());
                abort_run();
            end
            expected_free += deq_count[q] / words_per_page - enq_count[q] / words_per_page;
        end
        check_value("free_pages", 64'(expected_free), 64'(free_pages));

        if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// File: files.f
verilog/qbuf_pkg.sv
verilog/page_free_list.sv
verilog/queue_pointer_table.sv
verilog/queue_word_memory.sv
verilog/qbuf_top.sv
tb/qbuf_properties.sv
tb/qbuf_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the packet buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module qbuf_tb -f files.f -o qbuf_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/qbuf_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "PASS: all tests" "$log"; then
    echo "Simulation passed"
    exit 0
fi
echo "Pass message not found in $log"
exit 1
